/* hdl/conv_cfg.svh */
`ifndef CONV_CFG_SVH
`define CONV_CFG_SVH

// frame geometry
`define IMAGE_WIDTH 16
`define IMAGE_HEIGHT 16

// pixels, weights and results are all signed 8 bit
`define PIXEL_WIDTH 8

// 3x3 kernel
`define TAP_COUNT 9
`define INDEX_WIDTH 4

// adder tree, leaves must be a power of two
`define MA_TREE_SIZE 16
`define PRODUCT_WIDTH 16
`define SUM_WIDTH 20

// one multiply stage plus log2(tree size) add levels
`define TREE_LATENCY 5

// arithmetic right shift after the bias add
`define OUT_SHIFT 6

`endif

/* hdl/conv_pkg.sv */
package conv_pkg;

  // host command opcodes, carried on cmd_op
  typedef enum logic [1:0] {
    op_load_weight = 2'd0,  // weight[cmd_index] <= cmd_data
    op_load_bias   = 2'd1,
    op_set_act     = 2'd2,  // bit 0 of cmd_data selects relu
    op_clear_frame = 2'd3   // restart row and column counters
  } cmd_op_t;

  // window controller states
  typedef enum logic [1:0] {
    st_idle = 2'd0,  // waiting for the first pixel of a frame
    st_fill = 2'd1,  // rows 0 and 1, line buffers still filling
    st_run  = 2'd2   // row 2 onward, windows can complete
  } window_state_t;

endpackage

/* hdl/kernel_store.sv */
`timescale 1ns/100ps
`include "conv_cfg.svh"

module kernel_store (
  input  logic                                  clock,
  input  logic                                  reset,
  input  logic                                  cmd_valid,
  input  conv_pkg::cmd_op_t                     cmd_op,
  input  logic [`INDEX_WIDTH-1:0]               cmd_index,
  input  logic [`PIXEL_WIDTH-1:0]               cmd_data,
  output logic [`TAP_COUNT*`PIXEL_WIDTH-1:0]    weights,
  output logic signed [`PIXEL_WIDTH-1:0]        bias,
  output logic                                  relu_enable,
  output logic                                  frame_clear
);
  import conv_pkg::*;

  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      weights     <= '0;
      bias        <= '0;
      relu_enable <= 1'b0;
      frame_clear <= 1'b0;
    end else begin
      frame_clear <= cmd_valid && (cmd_op == op_clear_frame);  // one cycle pulse
      if (cmd_valid) begin
        case (cmd_op)
          op_load_weight: begin
            if (cmd_index < `TAP_COUNT) begin  // taps 9..15 do not exist
              weights[cmd_index*`PIXEL_WIDTH +: `PIXEL_WIDTH] <= cmd_data;
            end
          end
          op_load_bias:   bias <= cmd_data;
          op_set_act:     relu_enable <= cmd_data[0];
          op_clear_frame: ;  // acts through frame_clear
          default:        ;
        endcase
      end
    end
  end

  // host must only address existing taps
  weight_index_in_range: assert property (
    @(posedge clock) disable iff (!reset)
    cmd_valid && (cmd_op == op_load_weight) |-> cmd_index < `TAP_COUNT
  ) else $error("weight write to tap %0d ignored", cmd_index);

endmodule

/* hdl/window_buffer.sv */
`timescale 1ns/100ps
`include "conv_cfg.svh"

module window_buffer (
  input  logic                                  clock,
  input  logic                                  reset,
  input  logic                                  pixel_valid,
  input  logic signed [`PIXEL_WIDTH-1:0]        pixel_data,
  input  logic                                  frame_clear,
  output logic                                  window_valid,
  output logic [`TAP_COUNT*`PIXEL_WIDTH-1:0]    window
);
  import conv_pkg::*;

  localparam int COL_W = $clog2(`IMAGE_WIDTH);
  localparam int ROW_W = $clog2(`IMAGE_HEIGHT);

  logic [`PIXEL_WIDTH-1:0] line_buf [2][`IMAGE_WIDTH];  // [0] holds the previous row and [1] the one before
  logic [`PIXEL_WIDTH-1:0] win [`TAP_COUNT];            // tap 0 top left in raster order
  logic [COL_W-1:0]        col_count;
  logic [ROW_W-1:0]        row_count;
  logic                    last_col;
  logic                    last_row;
  window_state_t           state;
  window_state_t           state_next;

  assign last_col = (col_count == COL_W'(`IMAGE_WIDTH - 1));
  assign last_row = (row_count == ROW_W'(`IMAGE_HEIGHT - 1));

  // row-long shift registers whose tail is the pixel one row above
  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      line_buf <= '{default: '{default: '0}};
    end else if (pixel_valid) begin
      line_buf[0][0] <= pixel_data;
      line_buf[1][0] <= line_buf[0][`IMAGE_WIDTH-1];
      for (int i = 1; i < `IMAGE_WIDTH; i++) begin
        line_buf[0][i] <= line_buf[0][i-1];
        line_buf[1][i] <= line_buf[1][i-1];
      end
    end
  end

  // window shifts left and the new column enters on the right
  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      win <= '{default: '0};
    end else if (pixel_valid) begin
      for (int r = 0; r < 3; r++) begin
        win[3*r]   <= win[3*r+1];
        win[3*r+1] <= win[3*r+2];
      end
      win[2] <= line_buf[1][`IMAGE_WIDTH-1];  // two rows up
      win[5] <= line_buf[0][`IMAGE_WIDTH-1];  // one row up
      win[8] <= pixel_data;
    end
  end

  always_comb begin
    for (int k = 0; k < `TAP_COUNT; k++) begin
      window[k*`PIXEL_WIDTH +: `PIXEL_WIDTH] = win[k];
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      st_idle: if (pixel_valid) state_next = st_fill;
      st_fill: if (pixel_valid && last_col && row_count == ROW_W'(1)) state_next = st_run;
      st_run:  if (pixel_valid && last_col && last_row) state_next = st_idle;  // frame wraps
      default: state_next = st_idle;
    endcase
    if (frame_clear) state_next = st_idle;
  end

  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      state        <= st_idle;
      col_count    <= '0;
      row_count    <= '0;
      window_valid <= 1'b0;
    end else begin
      state        <= state_next;
      window_valid <= pixel_valid && (state == st_run) && (col_count >= COL_W'(2));
      if (frame_clear) begin
        col_count <= '0;
        row_count <= '0;
      end else if (pixel_valid) begin
        if (last_col) begin
          col_count <= '0;
          row_count <= last_row ? '0 : row_count + 1'b1;
        end else begin
          col_count <= col_count + 1'b1;
        end
      end
    end
  end

  no_pixel_on_clear: assert property (
    @(posedge clock) disable iff (!reset) !(pixel_valid && frame_clear)
  ) else $error("pixel strobe collides with frame clear");

  // line buffers are not yet full in the fill rows
  no_window_in_fill: assert property (
    @(posedge clock) disable iff (!reset) window_valid |-> $past(row_count) >= ROW_W'(2)
  ) else $error("window_valid from a pixel in the first two rows");

endmodule

/* hdl/mult_adder.sv */
`timescale 1ns/100ps
`include "conv_cfg.svh"

module mult_adder (
  input  logic                                  clock,
  input  logic                                  reset,
  input  logic                                  window_valid,
  input  logic [`TAP_COUNT*`PIXEL_WIDTH-1:0]    window,
  input  logic [`TAP_COUNT*`PIXEL_WIDTH-1:0]    weights,
  output logic                                  sum_valid,
  output logic signed [`SUM_WIDTH-1:0]          sum
);

  localparam int NODES = `MA_TREE_SIZE - 1;  // registered adders with node 0 as the root
  localparam int EXT   = `SUM_WIDTH - `PRODUCT_WIDTH;

  logic signed [`PRODUCT_WIDTH-1:0] product [`TAP_COUNT];
  logic signed [`SUM_WIDTH-1:0]     node [NODES];
  logic signed [`SUM_WIDTH-1:0]     tree [2*`MA_TREE_SIZE-1];  // adders first, then leaves
  logic [`TREE_LATENCY-1:0]         valid_pipe;
  logic signed [`SUM_WIDTH-1:0]     flat_sum;

  // multiplier bank
  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      product <= '{default: '0};
    end else begin
      for (int i = 0; i < `TAP_COUNT; i++) begin
        product[i] <= $signed(window[i*`PIXEL_WIDTH +: `PIXEL_WIDTH]) *
                      $signed(weights[i*`PIXEL_WIDTH +: `PIXEL_WIDTH]);
      end
    end
  end

  genvar g;
  generate
    for (g = 0; g < NODES; g++) begin : g_node
      assign tree[g] = node[g];
    end
    for (g = 0; g < `MA_TREE_SIZE; g++) begin : g_leaf
      if (g < `TAP_COUNT) begin : g_tap
        assign tree[NODES+g] = {{EXT{product[g][`PRODUCT_WIDTH-1]}}, product[g]};  // sign extend
      end else begin : g_pad
        assign tree[NODES+g] = '0;  // unused leaf
      end
    end
  endgenerate

  // heap layout where the children of k sit at 2k+1 and 2k+2
  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      node <= '{default: '0};
    end else begin
      for (int k = 0; k < NODES; k++) begin
        node[k] <= tree[2*k+1] + tree[2*k+2];
      end
    end
  end

  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      valid_pipe <= '0;
    end else begin
      valid_pipe <= {valid_pipe[`TREE_LATENCY-2:0], window_valid};
    end
  end

  assign sum_valid = valid_pipe[`TREE_LATENCY-1];
  assign sum       = tree[0];

  // plain sum over the taps without the tree
  always_comb begin
    flat_sum = '0;
    for (int i = 0; i < `TAP_COUNT; i++) begin
      flat_sum += `SUM_WIDTH'($signed(window[i*`PIXEL_WIDTH +: `PIXEL_WIDTH])) *
                  `SUM_WIDTH'($signed(weights[i*`PIXEL_WIDTH +: `PIXEL_WIDTH]));
    end
  end

  // the valid pipe must track the data path depth
  sum_valid_latency: assert property (
    @(posedge clock) disable iff (!reset)
    (sum_valid == $past(window_valid, `TREE_LATENCY)) &&
    (!sum_valid || sum == $past(flat_sum, `TREE_LATENCY))
  ) else $error("sum out of step with window_valid");

endmodule

/* hdl/output_stage.sv */
`timescale 1ns/100ps
`include "conv_cfg.svh"

module output_stage (
  input  logic                                  clock,
  input  logic                                  reset,
  input  logic                                  sum_valid,
  input  logic signed [`SUM_WIDTH-1:0]          sum,
  input  logic signed [`PIXEL_WIDTH-1:0]        bias,
  input  logic                                  relu_enable,
  output logic                                  result_valid,
  output logic signed [`PIXEL_WIDTH-1:0]        result_data
);

  localparam int EXT_W   = `SUM_WIDTH + 1;  // room for the bias add
  localparam int MAX_OUT = 2**(`PIXEL_WIDTH-1) - 1;
  localparam int MIN_OUT = -(2**(`PIXEL_WIDTH-1));

  logic signed [EXT_W-1:0]        biased;
  logic signed [EXT_W-1:0]        scaled;
  logic signed [EXT_W-1:0]        activated;
  logic signed [`PIXEL_WIDTH-1:0] saturated;

  always_comb begin
    biased    = EXT_W'(sum) + EXT_W'(bias);
    scaled    = biased >>> `OUT_SHIFT;
    activated = (relu_enable && scaled < 0) ? '0 : scaled;
    // clamp to signed 8 bit
    if (activated > MAX_OUT) begin
      saturated = `PIXEL_WIDTH'(MAX_OUT);
    end else if (activated < MIN_OUT) begin
      saturated = `PIXEL_WIDTH'(MIN_OUT);
    end else begin
      saturated = activated[`PIXEL_WIDTH-1:0];
    end
  end

  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      result_valid <= 1'b0;
      result_data  <= '0;
    end else begin
      result_valid <= sum_valid;
      if (sum_valid) result_data <= saturated;  // holds between results
    end
  end

  relu_never_negative: assert property (
    @(posedge clock) disable iff (!reset)
    result_valid && $past(relu_enable) |-> !result_data[`PIXEL_WIDTH-1]
  ) else $error("negative result with relu enabled");

endmodule

/* hdl/conv_engine.sv */
`timescale 1ns/100ps
`include "conv_cfg.svh"

module conv_engine (
  input  logic                                  clock,
  input  logic                                  reset,
  input  logic                                  cmd_valid,
  input  conv_pkg::cmd_op_t                     cmd_op,
  input  logic [`INDEX_WIDTH-1:0]               cmd_index,
  input  logic [`PIXEL_WIDTH-1:0]               cmd_data,
  input  logic                                  pixel_valid,
  input  logic signed [`PIXEL_WIDTH-1:0]        pixel_data,
  output logic                                  result_valid,
  output logic signed [`PIXEL_WIDTH-1:0]        result_data
);

  logic [`TAP_COUNT*`PIXEL_WIDTH-1:0] weights;
  logic signed [`PIXEL_WIDTH-1:0]     bias;
  logic                               relu_enable;
  logic                               frame_clear;
  logic                               window_valid;
  logic [`TAP_COUNT*`PIXEL_WIDTH-1:0] window;
  logic                               sum_valid;
  logic signed [`SUM_WIDTH-1:0]       sum;

  kernel_store u_kernel_store (
    .clock       (clock),
    .reset       (reset),
    .cmd_valid   (cmd_valid),
    .cmd_op      (cmd_op),
    .cmd_index   (cmd_index),
    .cmd_data    (cmd_data),
    .weights     (weights),
    .bias        (bias),
    .relu_enable (relu_enable),
    .frame_clear (frame_clear)
  );

  // pixel to window_valid is 1 cycle
  window_buffer u_window_buffer (
    .clock        (clock),
    .reset        (reset),
    .pixel_valid  (pixel_valid),
    .pixel_data   (pixel_data),
    .frame_clear  (frame_clear),
    .window_valid (window_valid),
    .window       (window)
  );

  // 5 more cycles through the tree
  mult_adder u_mult_adder (
    .clock        (clock),
    .reset        (reset),
    .window_valid (window_valid),
    .window       (window),
    .weights      (weights),
    .sum_valid    (sum_valid),
    .sum          (sum)
  );

  output_stage u_output_stage (
    .clock        (clock),
    .reset        (reset),
    .sum_valid    (sum_valid),
    .sum          (sum),
    .bias         (bias),
    .relu_enable  (relu_enable),
    .result_valid (result_valid),
    .result_data  (result_data)
  );

endmodule

/* verification/tb_clock_gen.sv */
`timescale 1ns/100ps

module tb_clock_gen #(
  parameter int PERIOD = 40  // ns
) (
  output logic clock
);

  initial begin
    clock = 1'b0;
    forever #(PERIOD / 2) clock = ~clock;
  end

endmodule

/* verification/conv_checker.sv */
`timescale 1ns/100ps
`include "conv_cfg.svh"

module conv_checker (
  input  logic                           clock,
  input  logic                           reset,
  input  logic                           cmd_valid,
  input  conv_pkg::cmd_op_t              cmd_op,
  input  logic [`INDEX_WIDTH-1:0]        cmd_index,
  input  logic [`PIXEL_WIDTH-1:0]        cmd_data,
  input  logic                           pixel_valid,
  input  logic signed [`PIXEL_WIDTH-1:0] pixel_data,
  input  logic                           result_valid,
  input  logic signed [`PIXEL_WIDTH-1:0] result_data,
  input  logic                           run_done,
  output int                             value_errors,
  output int                             protocol_errors,
  output int                             results_seen,
  output int                             pending
);
  import conv_pkg::*;

  localparam int LATENCY = 7;  // pixel strobe to result strobe

  logic signed [`PIXEL_WIDTH-1:0] weight [`TAP_COUNT];
  logic signed [`PIXEL_WIDTH-1:0] bias;
  logic                           relu;
  logic signed [`PIXEL_WIDTH-1:0] image [`IMAGE_HEIGHT][`IMAGE_WIDTH];
  int                             row;
  int                             col;
  int                             cycle;
  int                             expect_q [$];
  int                             stamp_q [$];  // cycle of the pixel that closed the window
  bit                             leftover_done;

  // dot product plus bias, then floor shift, relu and clamp
  function automatic int model_result(int r, int c);
    int acc;
    acc = int'(bias);
    for (int k = 0; k < `TAP_COUNT; k++) begin
      acc += int'(image[r - 2 + k / 3][c - 2 + k % 3]) * int'(weight[k]);
    end
    acc = acc >>> `OUT_SHIFT;
    if (relu && acc < 0) acc = 0;
    if (acc > 127) acc = 127;
    if (acc < -128) acc = -128;
    return acc;
  endfunction

  task automatic take_pixel();
    image[row][col] = pixel_data;
    if (row >= 2 && col >= 2) begin  // window complete
      expect_q.push_back(model_result(row, col));
      stamp_q.push_back(cycle);
    end
    if (col == `IMAGE_WIDTH - 1) begin
      col = 0;
      row = (row == `IMAGE_HEIGHT - 1) ? 0 : row + 1;  // frame wraps
    end else begin
      col++;
    end
  endtask

  task automatic compare_result();
    int expected;
    int stamp;
    results_seen++;
    if (expect_q.size() == 0) begin
      $display("result_valid at %0d ns with no window waiting for a result", $time);
      protocol_errors++;
    end else begin
      expected = expect_q.pop_front();
      stamp = stamp_q.pop_front();
      if (cycle - stamp != LATENCY) begin
        $display("result at %0d ns came %0d cycles after its pixel, not %0d",
                 $time, cycle - stamp, LATENCY);
        protocol_errors++;
      end
      if (result_data !== `PIXEL_WIDTH'(expected)) begin
        $display("ERROR at %0d ns: result_data expected %0d actual %0d",
                 $time, expected, result_data);
        value_errors++;
      end
    end
    if (relu && result_data[`PIXEL_WIDTH-1] === 1'b1) begin
      $display("negative result %0d at %0d ns with relu on", result_data, $time);
      protocol_errors++;
    end
  endtask

  always @(posedge clock) begin
    cycle++;
    if (!reset) begin
      weight = '{default: '0};
      bias = '0;
      relu = 1'b0;
      row = 0;
      col = 0;
      if (result_valid) begin
        $display("result_valid high at %0d ns while reset is asserted", $time);
        protocol_errors++;
      end
    end else begin
      if (result_valid) compare_result();
      if (cmd_valid) begin
        case (cmd_op)
          op_load_weight: if (cmd_index < `TAP_COUNT) weight[cmd_index] = cmd_data;
          op_load_bias:   bias = cmd_data;
          op_set_act:     relu = cmd_data[0];
          op_clear_frame: begin
            row = 0;
            col = 0;
          end
          default: ;
        endcase
      end
      if (pixel_valid) take_pixel();
      if (run_done && !leftover_done) begin
        leftover_done = 1'b1;
        if (expect_q.size() != 0) begin
          $display("%0d expected results never arrived", expect_q.size());
          protocol_errors++;
        end
      end
    end
    pending = expect_q.size();
  end

endmodule

/* verification/conv_tb.sv */
`timescale 1ns/100ps
`include "conv_cfg.svh"

module conv_tb;
  import conv_pkg::*;

  localparam int FRAME_PIXELS    = `IMAGE_WIDTH * `IMAGE_HEIGHT;
  localparam int FRAME_RESULTS   = (`IMAGE_WIDTH - 2) * (`IMAGE_HEIGHT - 2);
  localparam int FRAMES          = 9;  // eight full frames plus one cut short
  localparam int WATCHDOG_CYCLES = FRAMES * FRAME_PIXELS * 3 + 500;

  logic                           clock;
  logic                           reset;
  logic                           cmd_valid;
  cmd_op_t                        cmd_op;
  logic [`INDEX_WIDTH-1:0]        cmd_index;
  logic [`PIXEL_WIDTH-1:0]        cmd_data;
  logic                           pixel_valid;
  logic signed [`PIXEL_WIDTH-1:0] pixel_data;
  logic                           result_valid;
  logic signed [`PIXEL_WIDTH-1:0] result_data;
  logic                           run_done;
  int                             value_errors;
  int                             protocol_errors;
  int                             results_seen;
  int                             pending;
  int                             sequence_errors;
  int                             first_result;
  logic [15:0]                    lfsr;

  tb_clock_gen #(.PERIOD(40)) clock_gen (.clock(clock));

  conv_engine UUT (
    .clock        (clock),
    .reset        (reset),
    .cmd_valid    (cmd_valid),
    .cmd_op       (cmd_op),
    .cmd_index    (cmd_index),
    .cmd_data     (cmd_data),
    .pixel_valid  (pixel_valid),
    .pixel_data   (pixel_data),
    .result_valid (result_valid),
    .result_data  (result_data)
  );

  conv_checker result_check (
    .clock           (clock),
    .reset           (reset),
    .cmd_valid       (cmd_valid),
    .cmd_op          (cmd_op),
    .cmd_index       (cmd_index),
    .cmd_data        (cmd_data),
    .pixel_valid     (pixel_valid),
    .pixel_data      (pixel_data),
    .result_valid    (result_valid),
    .result_data     (result_data),
    .run_done        (run_done),
    .value_errors    (value_errors),
    .protocol_errors (protocol_errors),
    .results_seen    (results_seen),
    .pending         (pending)
  );

  // fibonacci lfsr x^16 + x^14 + x^13 + x^11 + 1, one step per bit
  function automatic int random_bits(int count);
    int value;
    value = 0;
    for (int i = 0; i < count; i++) begin
      lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
      value = (value << 1) | int'(lfsr[0]);
    end
    return value;
  endfunction

  // all drive tasks start and end on a falling edge
  task automatic send_command(cmd_op_t op, int index, int data);
    cmd_valid = 1'b1;
    cmd_op = op;
    cmd_index = index[`INDEX_WIDTH-1:0];
    cmd_data = data[`PIXEL_WIDTH-1:0];
    @(negedge clock);
    cmd_valid = 1'b0;
  endtask

  task automatic send_pixel(int value);
    pixel_valid = 1'b1;
    pixel_data = value[`PIXEL_WIDTH-1:0];
    @(negedge clock);
    pixel_valid = 1'b0;
    if (random_bits(1) == 1) begin
      repeat (1 + random_bits(1)) @(negedge clock);  // idle gap of 1 or 2
    end
  endtask

  task automatic stream_pixels(int count, bit use_random, int value);
    for (int i = 0; i < count; i++) begin
      send_pixel(use_random ? random_bits(8) : value);
    end
  endtask

  task automatic load_kernel(bit use_random, int weight_value, int bias_value);
    for (int k = 0; k < `TAP_COUNT; k++) begin
      send_command(op_load_weight, k, use_random ? random_bits(8) : weight_value);
    end
    send_command(op_load_bias, 0, use_random ? random_bits(8) : bias_value);
  endtask

  task automatic drain_pipeline();
    int waited;
    waited = 0;
    while (pending != 0 && waited < 4 * `TREE_LATENCY + 20) begin
      @(negedge clock);
      waited++;
    end
    if (pending != 0) begin
      $display("pipeline did not drain, %0d results still expected", pending);
      sequence_errors++;
    end
    repeat (3) @(negedge clock);
  endtask

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clock);
    $display("timeout after %0d clock cycles, test sequence did not finish", WATCHDOG_CYCLES);
    $display("=== FAIL ===");
    $finish;
  end

  initial begin
    lfsr = 16'd66;
    reset = 1'b0;
    cmd_valid = 1'b0;
    cmd_op = op_load_weight;
    cmd_index = '0;
    cmd_data = '0;
    pixel_valid = 1'b0;
    pixel_data = '0;
    run_done = 1'b0;
    sequence_errors = 0;
    repeat (8) @(negedge clock);
    reset = 1'b1;
    @(negedge clock);

    // one-hot centre tap, result is the centre pixel shifted down
    load_kernel(1'b0, 0, 0);
    send_command(op_load_weight, 4, 1);
    send_command(op_set_act, 0, 0);
    first_result = results_seen;
    stream_pixels(FRAME_PIXELS, 1'b1, 0);
    drain_pipeline();
    if (results_seen - first_result != FRAME_RESULTS) begin
      $display("one-hot frame gave %0d results instead of %0d",
               results_seen - first_result, FRAME_RESULTS);
      sequence_errors++;
    end

    load_kernel(1'b1, 0, 0);
    stream_pixels(3 * FRAME_PIXELS, 1'b1, 0);  // frames wrap on their own
    drain_pipeline();

    send_command(op_set_act, 0, 1);  // relu
    stream_pixels(FRAME_PIXELS, 1'b1, 0);
    drain_pipeline();

    // saturation at both ends
    send_command(op_set_act, 0, 0);
    load_kernel(1'b0, 127, 127);
    stream_pixels(FRAME_PIXELS, 1'b0, 127);
    drain_pipeline();
    load_kernel(1'b0, 127, -128);
    stream_pixels(FRAME_PIXELS, 1'b0, -128);
    drain_pipeline();

    // clear in row 5 with windows still in flight
    load_kernel(1'b1, 0, 0);
    stream_pixels(5 * `IMAGE_WIDTH + 7, 1'b1, 0);
    send_command(op_clear_frame, 0, 0);
    @(negedge clock);  // frame_clear pulse, no pixel allowed
    stream_pixels(FRAME_PIXELS, 1'b1, 0);
    drain_pipeline();

    run_done = 1'b1;
    repeat (2) @(negedge clock);
    $display("errors: %0d value, %0d protocol, %0d sequence; %0d results checked",
             value_errors, protocol_errors, sequence_errors, results_seen);
    if (value_errors + protocol_errors + sequence_errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

/* flist.f */
+incdir+hdl
hdl/conv_pkg.sv
hdl/kernel_store.sv
hdl/window_buffer.sv
hdl/mult_adder.sv
hdl/output_stage.sv
hdl/conv_engine.sv
verification/tb_clock_gen.sv
verification/conv_checker.sv
verification/conv_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the conv_engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module conv_tb -f flist.f -o conv_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

sim_output=$(./obj_dir/conv_sim)
sim_status=$?
printf '%s\n' "$sim_output"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$sim_output" | grep -qx "=== PASS ==="; then
  exit 0
fi
echo "simulation did not report a pass"
exit 1
